//--- hdl/lc3b_params.svh
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

////////////////////////////////////////////////////////////////////////
// widths fixed by the isa
////////////////////////////////////////////////////////////////////////

// data and address width
`define LC3B_WORD_W 16

// general purpose registers r0..r7
`define LC3B_NUM_REGS 8

// first fetch address out of reset
`define LC3B_RESET_PC 16'h0000

// size of the modelled memory, in words
`define LC3B_MEM_WORDS 256

`endif

//--- hdl/lc3b_types.sv
`include "lc3b_params.svh"

package lc3b_types;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

	// n, z, p from msb to lsb
	typedef logic [2:0] lc3b_nzp;

	// full lc3b opcode map, only part of it is executed
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_alu_op;

	// value written back to the register file
	typedef enum logic [1:0] {
		wb_alu,
		wb_address,
		wb_rdata
	} lc3b_wb_sel;

endpackage : lc3b_types

//--- hdl/lc3b_regfile.sv
`include "lc3b_params.svh"

module lc3b_regfile import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic write,
	input lc3b_reg dest,
	input lc3b_word wdata,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);

lc3b_word regs [`LC3B_NUM_REGS];

always_ff @(posedge clk)
begin
	if (reset)
	begin
		for (int i = 0; i < `LC3B_NUM_REGS; i++)
			regs[i] <= '0;
	end
	else if (write)
		regs[dest] <= wdata;
end

// no write bypass, decode stalls on pending writers instead
assign reg_a = regs[src_a];
assign reg_b = regs[src_b];

endmodule : lc3b_regfile

//--- hdl/lc3b_decode.sv
module lc3b_decode import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic advance,
	input logic flush,
	input lc3b_word inst_rdata,
	input lc3b_word pc_next,
	input lc3b_word reg_a,
	input lc3b_word reg_b,
	input lc3b_reg ex_dest,
	input logic ex_writes,
	input lc3b_reg res_dest,
	input logic res_writes,
	output lc3b_reg src_a,
	output lc3b_reg src_b,
	output logic stall,
	output logic de_valid,
	output lc3b_opcode de_opcode,
	output lc3b_alu_op de_alu_op,
	output lc3b_wb_sel de_wb_sel,
	output logic de_use_imm,
	output logic de_writes,
	output logic de_sets_cc,
	output logic de_read_mem,
	output logic de_write_mem,
	output lc3b_reg de_dest,
	output lc3b_word de_op_a,
	output lc3b_word de_op_b,
	output lc3b_word de_ir,
	output lc3b_word de_pc
);

lc3b_word ir, ir_pc;
logic ir_valid;
lc3b_opcode opcode;
lc3b_alu_op alu_op;
lc3b_wb_sel wb_sel;
logic uses_a, uses_b, writes, sets_cc, read_mem, write_mem, use_imm;
logic hit_a, hit_b;
logic next_valid;

//////////////////////////////////////////////////////////////////////
// instruction register
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk)
begin
	if (advance && !stall)
	begin
		ir <= inst_rdata;
		ir_pc <= pc_next;
	end
end

always_ff @(posedge clk)
begin
	if (reset)
		ir_valid <= 1'b0;
	else if (advance)
	begin
		if (flush)
			ir_valid <= 1'b0;
		else if (!stall)
			ir_valid <= 1'b1;
	end
end

//////////////////////////////////////////////////////////////////////
// control decode
//////////////////////////////////////////////////////////////////////

assign opcode = lc3b_opcode'(ir[15:12]);
assign use_imm = ir[5];

always_comb
begin
	alu_op = alu_pass;
	wb_sel = wb_alu;
	uses_a = 1'b0;
	uses_b = 1'b0;
	writes = 1'b0;
	sets_cc = 1'b0;
	read_mem = 1'b0;
	write_mem = 1'b0;
	case (opcode)
		op_add, op_and:
		begin
			alu_op = (opcode == op_add) ? alu_add : alu_and;
			uses_a = 1'b1;
			uses_b = !ir[5];
			writes = 1'b1;
			sets_cc = 1'b1;
		end
		op_not:
		begin
			alu_op = alu_not;
			uses_a = 1'b1;
			writes = 1'b1;
			sets_cc = 1'b1;
		end
		// lc3b lea leaves the codes alone
		op_lea:
		begin
			wb_sel = wb_address;
			writes = 1'b1;
		end
		op_ldr:
		begin
			wb_sel = wb_rdata;
			uses_a = 1'b1;
			writes = 1'b1;
			sets_cc = 1'b1;
			read_mem = 1'b1;
		end
		op_str:
		begin
			uses_a = 1'b1;
			uses_b = 1'b1;
			write_mem = 1'b1;
		end
		default:
		begin
			alu_op = alu_pass;
		end
	endcase
end

// str reads its source from the dr field
assign src_a = ir[8:6];
assign src_b = (opcode == op_str) ? ir[11:9] : ir[2:0];

// true when a younger read would see a stale register
assign hit_a = (ex_writes && ex_dest == src_a) || (res_writes && res_dest == src_a);
assign hit_b = (ex_writes && ex_dest == src_b) || (res_writes && res_dest == src_b);

assign stall = ir_valid && ((uses_a && hit_a) || (uses_b && hit_b));

//////////////////////////////////////////////////////////////////////
// decode to execute register
//////////////////////////////////////////////////////////////////////

assign next_valid = ir_valid && !stall && !flush;

always_ff @(posedge clk)
begin
	if (reset)
	begin
		de_valid <= 1'b0;
		de_writes <= 1'b0;
		de_sets_cc <= 1'b0;
		de_read_mem <= 1'b0;
		de_write_mem <= 1'b0;
	end
	else if (advance)
	begin
		de_valid <= next_valid;
		de_writes <= next_valid && writes;
		de_sets_cc <= next_valid && sets_cc;
		de_read_mem <= next_valid && read_mem;
		de_write_mem <= next_valid && write_mem;
	end
end

always_ff @(posedge clk)
begin
	if (advance)
	begin
		de_opcode <= opcode;
		de_alu_op <= alu_op;
		de_wb_sel <= wb_sel;
		de_use_imm <= use_imm;
		de_dest <= ir[11:9];
		de_op_a <= reg_a;
		de_op_b <= reg_b;
		de_ir <= ir;
		de_pc <= ir_pc;
	end
end

endmodule : lc3b_decode

//--- hdl/lc3b_execute.sv
module lc3b_execute import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic advance,
	input logic flush,
	input logic de_valid,
	input lc3b_opcode de_opcode,
	input lc3b_alu_op de_alu_op,
	input lc3b_wb_sel de_wb_sel,
	input logic de_use_imm,
	input logic de_writes,
	input logic de_sets_cc,
	input logic de_read_mem,
	input logic de_write_mem,
	input lc3b_reg de_dest,
	input lc3b_word de_op_a,
	input lc3b_word de_op_b,
	input lc3b_word de_ir,
	input lc3b_word de_pc,
	output logic ex_valid,
	output logic ex_writes,
	output logic ex_sets_cc,
	output logic ex_read_mem,
	output logic ex_write_mem,
	output lc3b_reg ex_dest,
	output lc3b_opcode ex_opcode,
	output lc3b_wb_sel ex_wb_sel,
	output lc3b_word ex_alu_out,
	output lc3b_word ex_address,
	output lc3b_word ex_store_data,
	output lc3b_nzp ex_nzp_mask
);

lc3b_word imm5, offset6, offset9;
lc3b_word alu_b, alu_out, address;
logic keep;

// offsets are word offsets, hence the shift by one
assign imm5 = {{11{de_ir[4]}}, de_ir[4:0]};
assign offset6 = {{9{de_ir[5]}}, de_ir[5:0], 1'b0};
assign offset9 = {{6{de_ir[8]}}, de_ir[8:0], 1'b0};

assign alu_b = de_use_imm ? imm5 : de_op_b;

always_comb
begin
	case (de_alu_op)
		alu_add: alu_out = de_op_a + alu_b;
		alu_and: alu_out = de_op_a & alu_b;
		alu_not: alu_out = ~de_op_a;
		default: alu_out = de_op_a;
	endcase
end

// base + offset6 for loads and stores, pc relative otherwise
assign address = (de_opcode == op_ldr || de_opcode == op_str) ?
	de_op_a + offset6 : de_pc + offset9;

//////////////////////////////////////////////////////////////////////
// execute to result register
//////////////////////////////////////////////////////////////////////

assign keep = de_valid && !flush;

always_ff @(posedge clk)
begin
	if (reset)
	begin
		ex_valid <= 1'b0;
		ex_writes <= 1'b0;
		ex_sets_cc <= 1'b0;
		ex_read_mem <= 1'b0;
		ex_write_mem <= 1'b0;
	end
	else if (advance)
	begin
		ex_valid <= keep;
		ex_writes <= keep && de_writes;
		ex_sets_cc <= keep && de_sets_cc;
		ex_read_mem <= keep && de_read_mem;
		ex_write_mem <= keep && de_write_mem;
	end
end

always_ff @(posedge clk)
begin
	if (advance)
	begin
		ex_dest <= de_dest;
		ex_opcode <= de_opcode;
		ex_wb_sel <= de_wb_sel;
		ex_alu_out <= alu_out;
		ex_address <= address;
		ex_store_data <= de_op_b;
		ex_nzp_mask <= de_ir[11:9];
	end
end

endmodule : lc3b_execute

//--- hdl/lc3b_result.sv
module lc3b_result import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic advance,
	input lc3b_word data_rdata,
	input logic data_resp,
	input logic ex_valid,
	input logic ex_writes,
	input logic ex_sets_cc,
	input logic ex_read_mem,
	input logic ex_write_mem,
	input lc3b_reg ex_dest,
	input lc3b_opcode ex_opcode,
	input lc3b_wb_sel ex_wb_sel,
	input lc3b_word ex_alu_out,
	input lc3b_word ex_address,
	input lc3b_word ex_store_data,
	input lc3b_nzp ex_nzp_mask,
	output logic data_read,
	output logic data_write,
	output lc3b_word data_address,
	output lc3b_word data_wdata,
	output logic reg_write,
	output lc3b_reg reg_dest,
	output lc3b_word reg_wdata,
	output logic branch_taken,
	output lc3b_word branch_target
);

logic data_hold;
lc3b_word rdata_buf, load_data;
lc3b_nzp cc, cc_next;

// response already taken while the fetch side was still busy
always_ff @(posedge clk)
begin
	if (reset || advance)
		data_hold <= 1'b0;
	else if (data_resp)
		data_hold <= 1'b1;
end

always_ff @(posedge clk)
begin
	if (data_resp)
		rdata_buf <= data_rdata;
end

assign data_read = ex_read_mem && !data_hold;
assign data_write = ex_write_mem && !data_hold;
assign data_address = ex_address;
assign data_wdata = ex_store_data;

assign load_data = data_hold ? rdata_buf : data_rdata;

always_comb
begin
	case (ex_wb_sel)
		wb_address: reg_wdata = ex_address;
		wb_rdata: reg_wdata = load_data;
		default: reg_wdata = ex_alu_out;
	endcase
end

assign cc_next = {reg_wdata[15], reg_wdata == '0, !reg_wdata[15] && reg_wdata != '0};

always_ff @(posedge clk)
begin
	if (reset)
		cc <= '0;
	else if (advance && ex_sets_cc)
		cc <= cc_next;
end

assign reg_write = advance && ex_writes;
assign reg_dest = ex_dest;

// codes already hold the result of the previous instruction
assign branch_taken = ex_valid && ex_opcode == op_br && |(ex_nzp_mask & cc);
assign branch_target = ex_address;

endmodule : lc3b_result

//--- hdl/lc3b_datapath.sv
`include "lc3b_params.svh"

module lc3b_datapath import lc3b_types::*;
(
	input logic clk,
	input logic reset,

	// instruction port
	output logic inst_read,
	output lc3b_word inst_address,
	input logic inst_resp,
	input lc3b_word inst_rdata,

	// data port
	output logic data_read,
	output logic data_write,
	output lc3b_word data_address,
	output lc3b_word data_wdata,
	input logic data_resp,
	input lc3b_word data_rdata,

	// register write observation
	output logic reg_write,
	output lc3b_reg reg_dest,
	output lc3b_word reg_wdata
);

lc3b_word pc, pc_next, inst_buf, inst_word;
logic inst_hold, advance, stall, flush;
logic branch_taken;
lc3b_word branch_target;
lc3b_reg src_a, src_b;
lc3b_word reg_a, reg_b;

// decode to execute
logic de_valid, de_use_imm, de_writes, de_sets_cc, de_read_mem, de_write_mem;
lc3b_opcode de_opcode;
lc3b_alu_op de_alu_op;
lc3b_wb_sel de_wb_sel;
lc3b_reg de_dest;
lc3b_word de_op_a, de_op_b, de_ir, de_pc;

// execute to result
logic ex_valid, ex_writes, ex_sets_cc, ex_read_mem, ex_write_mem;
lc3b_reg ex_dest;
lc3b_opcode ex_opcode;
lc3b_wb_sel ex_wb_sel;
lc3b_word ex_alu_out, ex_address, ex_store_data;
lc3b_nzp ex_nzp_mask;

//////////////////////////////////////////////////////////////////////
// fetch and global advance
//////////////////////////////////////////////////////////////////////

// whole pipe moves only when neither port is waiting
assign advance = (!inst_read || inst_resp) && (!(data_read || data_write) || data_resp);
assign flush = branch_taken;

always_ff @(posedge clk)
begin
	if (reset || advance)
		inst_hold <= 1'b0;
	else if (inst_resp)
		inst_hold <= 1'b1;
end

always_ff @(posedge clk)
begin
	if (inst_resp)
		inst_buf <= inst_rdata;
end

assign inst_word = inst_hold ? inst_buf : inst_rdata;
assign inst_read = !inst_hold;
assign inst_address = pc;
assign pc_next = pc + lc3b_word'(2);

always_ff @(posedge clk)
begin
	if (reset)
		pc <= `LC3B_RESET_PC;
	else if (advance)
	begin
		if (branch_taken)
			pc <= branch_target;
		else if (!stall)
			pc <= pc_next;
	end
end

//////////////////////////////////////////////////////////////////////
// stages
//////////////////////////////////////////////////////////////////////

lc3b_regfile regfile
(
	.clk, .reset,
	.write(reg_write), .dest(reg_dest), .wdata(reg_wdata),
	.src_a, .src_b, .reg_a, .reg_b
);

lc3b_decode decode
(
	.clk, .reset, .advance, .flush,
	.inst_rdata(inst_word), .pc_next, .reg_a, .reg_b,
	.ex_dest(de_dest), .ex_writes(de_writes),
	.res_dest(ex_dest), .res_writes(ex_writes),
	.src_a, .src_b, .stall,
	.de_valid, .de_opcode, .de_alu_op, .de_wb_sel, .de_use_imm,
	.de_writes, .de_sets_cc, .de_read_mem, .de_write_mem,
	.de_dest, .de_op_a, .de_op_b, .de_ir, .de_pc
);

lc3b_execute execute
(
	.clk, .reset, .advance, .flush,
	.de_valid, .de_opcode, .de_alu_op, .de_wb_sel, .de_use_imm,
	.de_writes, .de_sets_cc, .de_read_mem, .de_write_mem,
	.de_dest, .de_op_a, .de_op_b, .de_ir, .de_pc,
	.ex_valid, .ex_writes, .ex_sets_cc, .ex_read_mem, .ex_write_mem,
	.ex_dest, .ex_opcode, .ex_wb_sel, .ex_alu_out, .ex_address,
	.ex_store_data, .ex_nzp_mask
);

lc3b_result result
(
	.clk, .reset, .advance, .data_rdata, .data_resp,
	.ex_valid, .ex_writes, .ex_sets_cc, .ex_read_mem, .ex_write_mem,
	.ex_dest, .ex_opcode, .ex_wb_sel, .ex_alu_out, .ex_address,
	.ex_store_data, .ex_nzp_mask,
	.data_read, .data_write, .data_address, .data_wdata,
	.reg_write, .reg_dest, .reg_wdata,
	.branch_taken, .branch_target
);

endmodule : lc3b_datapath

//--- verification/lc3b_tb.sv
`include "lc3b_params.svh"

module lc3b_tb import lc3b_types::*;
;

timeunit 1ns;
timeprecision 1ps;

localparam int PROG_LEN = 64;
localparam lc3b_word END_PC = lc3b_word'(2 * (PROG_LEN - 1));
localparam lc3b_word DATA_BASE = 16'h0100;
localparam int DRAIN_LIMIT = 20000;
localparam int LOOP_LIMIT = 200;

// one expected architectural event, register write or store
typedef struct packed {
	logic is_store;
	lc3b_reg dest;
	lc3b_word address;
	lc3b_word value;
} exp_event;

logic clk, reset;
logic inst_read, inst_resp;
lc3b_word inst_address, inst_rdata;
logic data_read, data_write, data_resp;
lc3b_word data_address, data_wdata, data_rdata;
logic reg_write;
lc3b_reg reg_dest;
lc3b_word reg_wdata;

lc3b_word mem [`LC3B_MEM_WORDS];
lc3b_word ref_mem [`LC3B_MEM_WORDS];
exp_event expect_q [$];
int end_fetches;
int lat_tab [256];
int lat_idx;
int inst_wait, data_wait;
logic was_reset;

lc3b_datapath UUT
(
	.clk, .reset,
	.inst_read, .inst_address, .inst_resp, .inst_rdata,
	.data_read, .data_write, .data_address, .data_wdata, .data_resp, .data_rdata,
	.reg_write, .reg_dest, .reg_wdata
);

always #10 clk = ~clk;

task automatic fail_run(string why);
	$display("%s", why);
	$display("Simulation finished: FAIL");
	$fatal(1, "run stopped on first error");
endtask

task automatic compare_word(string name, lc3b_word expected, lc3b_word actual);
	if (expected !== actual)
		fail_run($sformatf("Error: %s expected %h, got %h", name, expected, actual));
endtask

task automatic compare_reg(string name, lc3b_reg expected, lc3b_reg actual);
	if (expected !== actual)
		fail_run($sformatf("Error: %s expected %h, got %h", name, expected, actual));
endtask

task automatic compare_bit(string name, logic expected, logic actual);
	if (expected !== actual)
		fail_run($sformatf("Error: %s expected %h, got %h", name, expected, actual));
endtask

task automatic compare_kind(logic expected_store, logic actual_store);
	if (expected_store && !actual_store)
		fail_run("a register write arrived where the reference expected a store");
	else if (!expected_store && actual_store)
		fail_run("a store arrived where the reference expected a register write");
endtask

////////////////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////////////////

function automatic lc3b_word sext(lc3b_word v, int bits);
	lc3b_word sign;
	lc3b_word field;
	sign = lc3b_word'(1) << (bits - 1);
	field = v & ((lc3b_word'(1) << bits) - lc3b_word'(1));
	return (field ^ sign) - sign;
endfunction

// byte address to word slot
function automatic int word_index(lc3b_word address);
	return (address >> 1) % `LC3B_MEM_WORDS;
endfunction

// runs the program in order, filling the expected queue
function automatic void run_reference();
	lc3b_word r [`LC3B_NUM_REGS];
	lc3b_word pc, ir, value, address;
	lc3b_nzp cc;
	logic writes, sets_cc;
	int steps;
	pc = `LC3B_RESET_PC;
	cc = '0;
	steps = 0;
	for (int i = 0; i < `LC3B_NUM_REGS; i++)
		r[i] = '0;
	while (pc != END_PC && steps < 4 * PROG_LEN)
	begin
		ir = ref_mem[word_index(pc)];
		pc = pc + 16'd2;
		writes = 1'b0;
		sets_cc = 1'b1;
		steps++;
		case (lc3b_opcode'(ir[15:12]))
			op_add:
			begin
				value = r[ir[8:6]] + (ir[5] ? sext(ir, 5) : r[ir[2:0]]);
				writes = 1'b1;
			end
			op_and:
			begin
				value = r[ir[8:6]] & (ir[5] ? sext(ir, 5) : r[ir[2:0]]);
				writes = 1'b1;
			end
			op_not:
			begin
				value = ~r[ir[8:6]];
				writes = 1'b1;
			end
			op_lea:
			begin
				value = pc + (sext(ir, 9) << 1);
				writes = 1'b1;
				sets_cc = 1'b0;
			end
			op_ldr:
			begin
				address = r[ir[8:6]] + (sext(ir, 6) << 1);
				value = ref_mem[word_index(address)];
				writes = 1'b1;
			end
			op_str:
			begin
				address = r[ir[8:6]] + (sext(ir, 6) << 1);
				ref_mem[word_index(address)] = r[ir[11:9]];
				expect_q.push_back('{1'b1, 3'd0, address, r[ir[11:9]]});
			end
			op_br:
			begin
				if ((ir[11:9] & cc) != 3'b000)
					pc = pc + (sext(ir, 9) << 1);
			end
			default:
			begin
				writes = 1'b0;
			end
		endcase
		if (writes)
		begin
			r[ir[11:9]] = value;
			expect_q.push_back('{1'b0, ir[11:9], 16'h0000, value});
			if (sets_cc)
			begin
				if (value[15])
					cc = 3'b100;
				else if (value == 16'h0000)
					cc = 3'b010;
				else
					cc = 3'b001;
			end
		end
	end
endfunction

////////////////////////////////////////////////////////////////////////
// program generator and memory model
////////////////////////////////////////////////////////////////////////

function automatic void build_program();
	lc3b_reg dr, sr1, sr2, last_dr;
	int off;
	for (int i = 0; i < `LC3B_MEM_WORDS; i++)
		mem[i] = lc3b_word'(i * 40503) ^ 16'h5a5a;
	// r7 points at the data region and is never overwritten
	mem[0] = {op_lea, 3'd7, 9'((DATA_BASE - 16'd2) >> 1)};
	mem[1] = {op_and, 3'd0, 3'd0, 1'b1, 5'd0};
	last_dr = 3'd0;
	for (int i = 2; i < PROG_LEN - 1; i++)
	begin
		dr = lc3b_reg'($urandom_range(0, 6));
		sr1 = $urandom_range(0, 1) ? last_dr : lc3b_reg'($urandom_range(0, 7));
		sr2 = lc3b_reg'($urandom_range(0, 7));
		case ($urandom_range(0, 8))
			0: mem[i] = {op_add, dr, sr1, 3'b000, sr2};
			1: mem[i] = {op_add, dr, sr1, 1'b1, 5'($urandom_range(0, 31))};
			2: mem[i] = {op_and, dr, sr1, 3'b000, sr2};
			3: mem[i] = {op_and, dr, sr1, 1'b1, 5'($urandom_range(0, 31))};
			4: mem[i] = {op_not, dr, sr1, 6'b111111};
			5: mem[i] = {op_lea, dr, 9'($urandom())};
			6: mem[i] = {op_ldr, dr, 3'd7, 6'($urandom_range(0, 31))};
			7: mem[i] = {op_str, sr2, 3'd7, 6'($urandom_range(0, 31))};
			default:
			begin
				// forward only, never past the final branch
				off = $urandom_range(0, 3);
				if (off > PROG_LEN - 2 - i)
					off = PROG_LEN - 2 - i;
				mem[i] = {op_br, 3'($urandom()), 9'(off)};
			end
		endcase
		last_dr = dr;
	end
	mem[PROG_LEN - 1] = {op_br, 3'b111, 9'h1ff};
endfunction

function automatic int next_latency();
	lat_idx = (lat_idx + 1) % 256;
	return lat_tab[lat_idx];
endfunction

// both ports answer 1 to 3 cycles after the request shows up
always @(posedge clk)
begin
	was_reset = reset;
	#1;
	inst_resp = 1'b0;
	data_resp = 1'b0;
	if (was_reset || !inst_read)
		inst_wait = 0;
	else if (inst_wait == 0)
		inst_wait = next_latency();
	else
	begin
		inst_wait--;
		if (inst_wait == 0)
		begin
			inst_resp = 1'b1;
			inst_rdata = mem[word_index(inst_address)];
		end
	end
	if (was_reset || !(data_read || data_write))
		data_wait = 0;
	else if (data_wait == 0)
		data_wait = next_latency();
	else
	begin
		data_wait--;
		if (data_wait == 0)
		begin
			data_resp = 1'b1;
			if (data_write)
				mem[word_index(data_address)] = data_wdata;
			else
				data_rdata = mem[word_index(data_address)];
		end
	end
end

////////////////////////////////////////////////////////////////////////
// compare process
////////////////////////////////////////////////////////////////////////

task automatic check_event(logic is_store);
	exp_event e;
	if (expect_q.size() == 0)
		fail_run("the DUT produced a register write or store after the reference ended");
	else
	begin
		e = expect_q.pop_front();
		compare_kind(e.is_store, is_store);
		if (is_store)
		begin
			compare_word("data_address", e.address, data_address);
			compare_word("data_wdata", e.value, data_wdata);
		end
		else
		begin
			compare_reg("reg_dest", e.dest, reg_dest);
			compare_word("reg_wdata", e.value, reg_wdata);
		end
	end
endtask

always @(negedge clk)
begin
	if (!reset)
	begin
		if (inst_read && inst_resp && inst_address == END_PC)
			end_fetches++;
		if (reg_write)
			check_event(1'b0);
		if (data_write && data_resp)
			check_event(1'b1);
	end
end

initial
begin
	int cycles;
	int loop_mark;
	clk = 1'b0;
	reset = 1'b1;
	inst_resp = 1'b0;
	inst_rdata = '0;
	data_resp = 1'b0;
	data_rdata = '0;
	end_fetches = 0;
	lat_idx = 0;
	inst_wait = 0;
	data_wait = 0;
	void'($urandom(62));
	for (int i = 0; i < 256; i++)
		lat_tab[i] = $urandom_range(1, 3);
	build_program();
	ref_mem = mem;
	run_reference();

	repeat (2) @(posedge clk);
	#1 reset = 1'b0;

	// state right out of reset
	@(negedge clk);
	compare_bit("data_read", 1'b0, data_read);
	compare_bit("data_write", 1'b0, data_write);
	compare_bit("reg_write", 1'b0, reg_write);
	compare_bit("inst_read", 1'b1, inst_read);
	compare_word("inst_address", `LC3B_RESET_PC, inst_address);

	cycles = 0;
	while (expect_q.size() != 0 && cycles < DRAIN_LIMIT)
	begin
		@(posedge clk);
		cycles++;
	end
	if (expect_q.size() != 0)
		fail_run("timed out waiting for the remaining register writes and stores");
	else
	begin
		// let the final branch loop twice so stray events would show up
		loop_mark = end_fetches + 2;
		cycles = 0;
		while (end_fetches < loop_mark && cycles < LOOP_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		if (end_fetches < loop_mark)
			fail_run("timed out waiting for the final branch to loop back to itself");
		else
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end
end

endmodule : lc3b_tb

//--- list.f
+incdir+hdl
hdl/lc3b_types.sv
hdl/lc3b_regfile.sv
hdl/lc3b_decode.sv
hdl/lc3b_execute.sv
hdl/lc3b_result.sv
hdl/lc3b_datapath.sv
verification/lc3b_tb.sv
